//--- Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_pkg.sv
      - logic/lsu_request_format.sv
      - logic/lsu_lane_port.sv
      - logic/lsu_response_commit.sv
      - logic/lsu_unit.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/tb_clock_gen.sv
      - tb/lsu_checker.sv
      - tb/lsu_asserts.sv
      - tb/lsu_tb.sv

//--- all.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_request_format.sv
logic/lsu_lane_port.sv
logic/lsu_response_commit.sv
logic/lsu_unit.sv
tb/tb_clock_gen.sv
tb/lsu_checker.sv
tb/lsu_asserts.sv
tb/lsu_tb.sv

//--- logic/lsu_lane_port.sv
`include "lsu_params.svh"

module lsu_lane_port import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue,
    input  lane_req_t               req,
    output logic                    ready,
    output logic                    mem_req_valid,
    output mem_req_t                mem_req,
    input  logic                    mem_req_ready,
    input  logic                    mem_rsp_valid,
    input  mem_rsp_t                mem_rsp,
    output logic                    done,
    output logic [`LSU_XLEN-1:0]    data,
    input  logic                    lane_release
);

    lane_state_e state;
    lane_req_t   req_q;
    logic [`LSU_XLEN-1:0] rsp_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (issue) begin
                        // masked-off lanes skip the memory port
                        state <= req.active ? REQ : DONE;
                    end
                end
                REQ: begin
                    if (mem_req_ready) begin
                        state <= req_q.rw ? DONE : WAIT_RSP;
                    end
                end
                WAIT_RSP: begin
                    if (mem_rsp_valid) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (lane_release) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && issue) begin
            req_q <= req;
        end
        if (state == WAIT_RSP && mem_rsp_valid) begin
            rsp_q <= mem_rsp.data;
        end
    end

    assign ready         = (state == IDLE);
    assign done          = (state == DONE);
    assign mem_req_valid = (state == REQ);
    assign mem_req       = '{rw: req_q.rw, addr: req_q.addr, byteen: req_q.byteen, data: req_q.data};
    assign data          = rsp_q;

endmodule

//--- logic/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// lanes per warp instruction
`define LSU_NUM_LANES 4

// data path is fixed at 32 bits
`define LSU_XLEN 32
`define LSU_WORD_BYTES (`LSU_XLEN / 8)

// byte address
`define LSU_ADDR_W 32

// derived from the word size
`define LSU_ALIGN_W $clog2(`LSU_WORD_BYTES)
`define LSU_WADDR_W (`LSU_ADDR_W - `LSU_ALIGN_W)

`define LSU_WID_W 2
`define LSU_RD_W 5

`endif

//--- logic/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

    // loads first, stores last
    typedef enum logic [2:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        IDLE, REQ, WAIT_RSP, DONE
    } lane_state_e;

    typedef struct packed {
        lsu_op_e                                    op;
        logic [`LSU_WID_W-1:0]                      wid;
        logic [`LSU_RD_W-1:0]                       rd;
        logic [`LSU_NUM_LANES-1:0]                  tmask;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   base;
        logic [`LSU_XLEN-1:0]                       imm;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   sdata;
    } lsu_instr_t;

    typedef struct packed {
        logic                       active;
        logic                       rw;
        logic [`LSU_WADDR_W-1:0]    addr;
        logic [`LSU_WORD_BYTES-1:0] byteen;
        logic [`LSU_XLEN-1:0]       data;
    } lane_req_t;

    typedef struct packed {
        logic                       rw;
        logic [`LSU_WADDR_W-1:0]    addr;
        logic [`LSU_WORD_BYTES-1:0] byteen;
        logic [`LSU_XLEN-1:0]       data;
    } mem_req_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        lsu_op_e                                        op;
        logic [`LSU_WID_W-1:0]                          wid;
        logic [`LSU_RD_W-1:0]                           rd;
        logic [`LSU_NUM_LANES-1:0]                      tmask;
        logic [`LSU_NUM_LANES-1:0][`LSU_ALIGN_W-1:0]    align;
    } lsu_ctx_t;

    typedef struct packed {
        logic [`LSU_WID_W-1:0]                      wid;
        logic [`LSU_RD_W-1:0]                       rd;
        logic [`LSU_NUM_LANES-1:0]                  tmask;
        logic                                       wb;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   data;
    } lsu_commit_t;

endpackage

//--- logic/lsu_request_format.sv
`include "lsu_params.svh"

module lsu_request_format import lsu_pkg::*; (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  lsu_instr_t                          in_data,
    output logic                                in_ready,
    output logic                                issue_valid,
    output lane_req_t [`LSU_NUM_LANES-1:0]      lane_req,
    input  logic [`LSU_NUM_LANES-1:0]           lane_ready,
    output lsu_ctx_t                            ctx,
    input  logic                                ctx_ready
);

    lsu_instr_t stage;
    logic       stage_valid;
    logic       running;
    logic       issue_fire;
    logic       is_store;
    logic [`LSU_NUM_LANES-1:0][`LSU_ALIGN_W-1:0] lane_align;

    assign issue_valid = stage_valid;
    assign issue_fire  = stage_valid && (&lane_ready) && ctx_ready;

    // running stays low while in reset
    assign in_ready = running && (!stage_valid || issue_fire);

    always_ff @(posedge clk) begin
        if (reset) begin
            running     <= 1'b0;
            stage_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (in_valid && in_ready) begin
                stage_valid <= 1'b1;
            end else if (issue_fire) begin
                stage_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            stage <= in_data;
        end
    end

    assign is_store = stage.op inside {SB, SH, SW};

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        logic [`LSU_ADDR_W-1:0]     addr;
        logic [`LSU_ALIGN_W-1:0]    align;
        logic [`LSU_WORD_BYTES-1:0] byteen;

        assign addr  = stage.base[i][`LSU_ADDR_W-1:0] + stage.imm[`LSU_ADDR_W-1:0];
        assign align = addr[`LSU_ALIGN_W-1:0];

        // enables follow access size
        always_comb begin
            case (stage.op)
                LB, LBU, SB: byteen = `LSU_WORD_BYTES'(1) << align;
                LH, LHU, SH: byteen = `LSU_WORD_BYTES'(3) << {align[`LSU_ALIGN_W-1:1], 1'b0};
                default:     byteen = '1;
            endcase
        end

        assign lane_req[i] = '{
            active: stage.tmask[i],
            rw:     is_store,
            addr:   addr[`LSU_ADDR_W-1:`LSU_ALIGN_W],
            byteen: byteen,
            data:   stage.sdata[i] << {align, 3'b000}
        };

        assign lane_align[i] = align;
    end

    always_comb begin
        ctx.op    = stage.op;
        ctx.wid   = stage.wid;
        ctx.rd    = stage.rd;
        ctx.tmask = stage.tmask;
        ctx.align = lane_align;
    end

endmodule

//--- logic/lsu_response_commit.sv
`include "lsu_params.svh"

module lsu_response_commit import lsu_pkg::*; (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        issue,
    input  lsu_ctx_t                                    ctx,
    output logic                                        ctx_ready,
    input  logic [`LSU_NUM_LANES-1:0]                   lane_done,
    input  logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]    lane_data,
    output logic                                        lane_release,
    output logic                                        commit_valid,
    output lsu_commit_t                                 commit,
    input  logic                                        commit_ready
);

    lsu_ctx_t ctx_q;
    logic     ctx_valid;
    logic     is_load;
    logic     load;
    wire [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0] ext_data;

    assign ctx_ready = !ctx_valid;
    assign is_load   = ctx_q.op inside {LB, LH, LW, LBU, LHU};

    // output register free or draining this cycle
    assign load         = ctx_valid && (&lane_done) && (!commit_valid || commit_ready);
    assign lane_release = load;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctx_valid    <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            if (issue) begin
                ctx_valid <= 1'b1;
            end else if (load) begin
                ctx_valid <= 1'b0;
            end
            if (load) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ctx_q <= ctx;
        end
    end

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_fmt
        logic [`LSU_XLEN-1:0] ext;
        logic [15:0]          half;
        logic [7:0]           bval;

        // pick half, then byte, by alignment
        assign half = ctx_q.align[i][1] ? lane_data[i][31:16] : lane_data[i][15:0];
        assign bval = ctx_q.align[i][0] ? half[15:8] : half[7:0];

        always_comb begin
            case (ctx_q.op)
                LB:      ext = `LSU_XLEN'(signed'(bval));
                LH:      ext = `LSU_XLEN'(signed'(half));
                LW:      ext = lane_data[i];
                LBU:     ext = `LSU_XLEN'(bval);
                LHU:     ext = `LSU_XLEN'(half);
                default: ext = '0;
            endcase
            if (!ctx_q.tmask[i]) begin
                ext = '0;
            end
        end

        assign ext_data[i] = ext;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            commit.wid   <= ctx_q.wid;
            commit.rd    <= ctx_q.rd;
            commit.tmask <= ctx_q.tmask;
            commit.wb    <= is_load;
            commit.data  <= ext_data;
        end
    end

endmodule

//--- logic/lsu_unit.sv
`include "lsu_params.svh"

module lsu_unit import lsu_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    input  lsu_instr_t                      in_data,
    output logic                            in_ready,
    output logic [`LSU_NUM_LANES-1:0]       mem_req_valid,
    output mem_req_t [`LSU_NUM_LANES-1:0]   mem_req,
    input  logic [`LSU_NUM_LANES-1:0]       mem_req_ready,
    input  logic [`LSU_NUM_LANES-1:0]       mem_rsp_valid,
    input  mem_rsp_t [`LSU_NUM_LANES-1:0]   mem_rsp,
    output logic                            commit_valid,
    output lsu_commit_t                     commit,
    input  logic                            commit_ready
);

    logic                                       issue_valid;
    logic                                       issue;
    lane_req_t [`LSU_NUM_LANES-1:0]             lane_req;
    logic [`LSU_NUM_LANES-1:0]                  lane_ready;
    logic [`LSU_NUM_LANES-1:0]                  lane_done;
    logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   lane_data;
    logic                                       lane_release;
    lsu_ctx_t                                   ctx;
    logic                                       ctx_ready;

    // all lanes and the committer take the instruction together
    assign issue = issue_valid && (&lane_ready) && ctx_ready;

    lsu_request_format request_format (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .issue_valid (issue_valid),
        .lane_req    (lane_req),
        .lane_ready  (lane_ready),
        .ctx         (ctx),
        .ctx_ready   (ctx_ready)
    );

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        lsu_lane_port lane_port (
            .clk           (clk),
            .reset         (reset),
            .issue         (issue),
            .req           (lane_req[i]),
            .ready         (lane_ready[i]),
            .mem_req_valid (mem_req_valid[i]),
            .mem_req       (mem_req[i]),
            .mem_req_ready (mem_req_ready[i]),
            .mem_rsp_valid (mem_rsp_valid[i]),
            .mem_rsp       (mem_rsp[i]),
            .done          (lane_done[i]),
            .data          (lane_data[i]),
            .lane_release  (lane_release)
        );
    end

    lsu_response_commit response_commit (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .ctx          (ctx),
        .ctx_ready    (ctx_ready),
        .lane_done    (lane_done),
        .lane_data    (lane_data),
        .lane_release (lane_release),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

//--- tb/lsu_asserts.sv
`include "lsu_params.svh"

module lsu_asserts import lsu_pkg::*; (
    input logic                              clk,
    input logic                              reset,
    input logic [`LSU_NUM_LANES-1:0]         mem_req_valid,
    input mem_req_t [`LSU_NUM_LANES-1:0]     mem_req,
    input logic [`LSU_NUM_LANES-1:0]         mem_req_ready,
    input logic                              commit_valid,
    input lsu_commit_t                       commit,
    input logic                              commit_ready,
    input logic                              issue,
    input lsu_ctx_t                          ctx
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;

    function automatic logic aligned(lsu_ctx_t c);
        logic ok = 1'b1;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            if (c.tmask[i] && c.op inside {LH, LHU, SH} && c.align[i][0]) ok = 1'b0;
            if (c.tmask[i] && c.op inside {LW, SW} && c.align[i] != 0) ok = 1'b0;
        end
        return ok;
    endfunction

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        a_req_hold: assert property (@(posedge clk) disable iff (reset)
            mem_req_valid[i] && !mem_req_ready[i] |=> mem_req_valid[i] && $stable(mem_req[i]))
            else begin $error("lane request dropped before accept"); fails++; end
    end

    a_commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin $error("commit changed under back-pressure"); fails++; end

    a_reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> !commit_valid && mem_req_valid == '0)
        else begin $error("valid raised during reset"); fails++; end

    a_aligned: assert property (@(posedge clk) disable iff (reset) issue |-> aligned(ctx))
        else begin $error("misaligned lane address"); fails++; end
endmodule

bind lsu_unit lsu_asserts asserts0 (.*);

//--- tb/lsu_checker.sv
`include "lsu_params.svh"

module lsu_checker import lsu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        commit_valid,
    input  lsu_commit_t commit,
    input  logic        commit_ready,
    input  logic        exp_push,
    input  lsu_commit_t exp_rec,
    output int          checked,
    output int          errors,
    output int          pending
);
    timeunit 1ns;
    timeprecision 1ps;

    lsu_commit_t exp_q[$];
    lsu_commit_t e;

    always @(posedge clk) begin
        if (reset) begin
            checked = 0;
            errors  = 0;
        end else begin
            if (exp_push) begin
                exp_q.push_back(exp_rec);
            end
            if (commit_valid && commit_ready) begin
                if (exp_q.size() == 0) begin
                    $display("commit arrived at %0t with no instruction outstanding", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    checked++;
                    if (commit.wid !== e.wid || commit.rd !== e.rd ||
                        commit.tmask !== e.tmask || commit.wb !== e.wb) begin
                        $display("ERR %0t: wid %0d rd %0d tmask %b wb %b, exp %0d %0d %b %b",
                                 $time, commit.wid, commit.rd, commit.tmask, commit.wb,
                                 e.wid, e.rd, e.tmask, e.wb);
                        errors++;
                    end
                    for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                        // inactive lanes carry no data
                        if (e.tmask[i] && commit.data[i] !== e.data[i]) begin
                            $display("ERR %0t: lane %0d data %h, exp %h",
                                     $time, i, commit.data[i], e.data[i]);
                            errors++;
                        end
                    end
                end
            end
        end
        pending = exp_q.size();
    end
endmodule

//--- tb/lsu_tb.sv
`include "lsu_params.svh"

module lsu_tb import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = `LSU_NUM_LANES;
    localparam int NUM_INSTR = 235;

    logic clk, reset, in_valid, in_ready, commit_valid, commit_ready, exp_push;
    lsu_instr_t in_data;
    lsu_commit_t commit, exp_rec;
    logic [N-1:0] mem_req_valid, mem_req_ready, mem_rsp_valid;
    mem_req_t [N-1:0] mem_req;
    mem_rsp_t [N-1:0] mem_rsp;
    logic [7:0] mem [0:255];
    logic [7:0] shadow [0:255];
    integer seed = 26159;
    int checked, errors, pending, tb_errors, req_exp, last_checked, last_errors;
    int req_seen [N];
    int req_wait [N];
    int rsp_wait [N];
    bit rsp_pending [N];
    logic [31:0] rsp_word [N];

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));
    lsu_unit dut0 (.*);
    lsu_checker check0 (.*);

    // each lane owns a 64-byte region, so lanes never touch the same word
    for (genvar i = 0; i < N; i++) begin : g_mem
        int idx;
        always @(negedge clk) begin
            mem_rsp_valid[i] = 1'b0;
            mem_req_ready[i] = 1'b0;
            if (reset) begin
                rsp_pending[i] = 0;
                req_wait[i]    = 0;
            end else begin
                if (rsp_pending[i] && rsp_wait[i] == 0) begin
                    mem_rsp_valid[i]  = 1'b1;
                    mem_rsp[i].data   = rsp_word[i];
                    rsp_pending[i]    = 0;
                end else if (rsp_pending[i]) begin
                    rsp_wait[i]--;
                end
                if (mem_req_valid[i] && req_wait[i] == 0) begin
                    mem_req_ready[i] = 1'b1;
                    req_seen[i]++;
                    idx = {mem_req[i].addr[5:0], 2'b00};
                    if (mem_req[i].rw) begin
                        for (int b = 0; b < 4; b++)
                            if (mem_req[i].byteen[b]) mem[idx+b] = mem_req[i].data[8*b+:8];
                    end else begin
                        rsp_word[i]    = {mem[idx+3], mem[idx+2], mem[idx+1], mem[idx]};
                        rsp_pending[i] = 1;
                        rsp_wait[i]    = $random(seed) & 3;
                    end
                    req_wait[i] = $random(seed) & 3;
                end else if (mem_req_valid[i]) begin
                    req_wait[i]--;
                end
            end
        end
    end

    always @(negedge clk) begin
        commit_ready = !reset && (($random(seed) & 3) != 0);
    end

    function automatic int op_size(lsu_op_e op);
        if (op inside {LB, LBU, SB}) return 1;
        if (op inside {LH, LHU, SH}) return 2;
        return 4;
    endfunction

    // expected commit from the instruction, updating the shadow memory
    function automatic lsu_commit_t predict(lsu_instr_t x);
        lsu_commit_t r;
        logic [7:0] a;
        r.wid   = x.wid;
        r.rd    = x.rd;
        r.tmask = x.tmask;
        r.wb    = x.op inside {LB, LH, LW, LBU, LHU};
        r.data  = '0;
        for (int i = 0; i < N; i++) begin
            a = 8'(x.base[i] + x.imm);
            if (x.tmask[i]) begin
                case (x.op)
                    LB:  r.data[i] = {{24{shadow[a][7]}}, shadow[a]};
                    LBU: r.data[i] = {24'h0, shadow[a]};
                    LH:  r.data[i] = {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
                    LHU: r.data[i] = {16'h0, shadow[a+1], shadow[a]};
                    LW:  r.data[i] = {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
                    default: begin
                        for (int b = 0; b < op_size(x.op); b++)
                            shadow[a+b] = x.sdata[i][8*b+:8];
                    end
                endcase
            end
        end
        return r;
    endfunction

    // off below zero picks a random offset, rounded down to the access size
    task automatic build(input lsu_op_e op, input logic [N-1:0] tmask, input int off,
                         output lsu_instr_t x);
        int o;
        x.op    = op;
        x.wid   = $random(seed);
        x.rd    = $random(seed);
        x.tmask = tmask;
        x.imm   = $random(seed) & 15;
        for (int i = 0; i < N; i++) begin
            o = (off < 0) ? ($random(seed) & 63) : off;
            o = o - o % op_size(op);
            x.base[i]  = i * 64 + o - x.imm;
            x.sdata[i] = $random(seed);
        end
    endtask

    task automatic send(input lsu_instr_t x);
        @(negedge clk);
        exp_push = 1'b0;
        in_valid = 1'b1;
        in_data  = x;
        while (!in_ready) @(negedge clk);
        exp_rec  = predict(x);
        exp_push = 1'b1;
        req_exp += $countones(x.tmask);
        @(posedge clk);
    endtask

    task automatic end_test(input string name);
        int seen = 0;
        @(negedge clk);
        in_valid = 1'b0;
        exp_push = 1'b0;
        while (pending != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        for (int i = 0; i < N; i++) seen += req_seen[i];
        if (seen != req_exp) begin
            $display("ERR %0t: %0d memory requests seen, expected %0d", $time, seen, req_exp);
            tb_errors++;
        end
        $display("%s: %0d commits checked, %0d errors", name, checked - last_checked,
                 errors + tb_errors - last_errors);
        last_checked = checked;
        last_errors  = errors + tb_errors;
    endtask

    initial begin
        #((NUM_INSTR * 40 + 16) * 4);
        $display("watchdog expired before all instructions committed");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        lsu_instr_t x;
        lsu_op_e load_ops [5] = '{LB, LH, LW, LBU, LHU};
        lsu_op_e store_ops [3] = '{SB, SH, SW};
        int total;
        in_valid = 1'b0;
        in_data  = '0;
        exp_push = 1'b0;
        exp_rec  = '0;
        commit_ready  = 1'b0;
        mem_req_ready = '0;
        mem_rsp_valid = '0;
        mem_rsp       = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a]    = 8'(a) + 8'h5A;
            shadow[a] = 8'(a) + 8'h5A;
        end

        @(posedge clk);
        repeat (15) begin
            @(negedge clk);
            if (in_ready !== 1'b0 || commit_valid !== 1'b0 || mem_req_valid !== '0) begin
                $display("outputs were active at %0t while reset was held", $time);
                tb_errors++;
            end
        end
        wait (!reset);
        // first cycle out of reset
        @(negedge clk);
        if (in_ready !== 1'b1) begin
            $display("in_ready did not rise after reset");
            tb_errors++;
        end
        if (commit_valid !== 1'b0 || mem_req_valid !== '0) begin
            $display("outputs were active at %0t after reset with nothing sent", $time);
            tb_errors++;
        end
        end_test("reset");

        foreach (load_ops[j])
            for (int al = 0; al < 4; al += op_size(load_ops[j])) begin
                build(load_ops[j], '1, 8 + al, x);
                send(x);
            end
        end_test("loads");

        foreach (store_ops[j])
            for (int al = 0; al < 4; al += op_size(store_ops[j])) begin
                build(store_ops[j], '1, 16 + al, x);
                send(x);
                build(LW, '1, 16, x);
                send(x);
            end
        end_test("stores");

        for (int j = 0; j < 8; j++) begin
            build(lsu_op_e'($random(seed) & 7), (j == 0) ? '0 : N'($random(seed)), -1, x);
            send(x);
        end
        end_test("thread mask");

        repeat (200) begin
            build(lsu_op_e'($random(seed) & 7), N'($random(seed)), -1, x);
            send(x);
        end
        end_test("random stream");

        total = errors + tb_errors + dut0.asserts0.fails;
        $display("commits checked %0d, errors %0d, assertion failures %0d",
                 checked, errors + tb_errors, dut0.asserts0.fails);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held over 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
    end
endmodule
